// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mmu
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/bus_req_queue.sv ====
`timescale 1ns/1ps

/*
 * Request FIFO towards the arbiter with credit flow control
 * o_req.valid lasts one cycle per request and spends one credit
 * o_space counts the translation that may already be in flight
 */
module bus_req_queue (
    input  logic                clk,
    input  logic                reset,
    input  mmu_pkg::xlate_t     i_xlate,        // Push on valid
    input  logic                i_credit_ret,   // One credit back
    output mmu_pkg::bus_req_t   o_req,          // Request to arbiter
    output logic                o_space         // Room for one more command
);

// ----------------------------------------
// Storage and state
// ----------------------------------------
logic [mmu_pkg::ADDR_BITS-1:0]      paddr_mem [mmu_pkg::QUEUE_DEPTH];
mmu_pkg::arb_opc_t                  opc_mem   [mmu_pkg::QUEUE_DEPTH];

logic [mmu_pkg::QPTR_BITS-1:0]      wr_ptr;
logic [mmu_pkg::QPTR_BITS-1:0]      rd_ptr;
logic [mmu_pkg::QCNT_BITS-1:0]      count;      // Stored entries
logic [mmu_pkg::CREDIT_BITS-1:0]    credits;    // Credits left at the arbiter
logic [mmu_pkg::QCNT_BITS:0]        pending;    // Stored plus in flight
logic                               push;
logic                               pop;

assign push    = i_xlate.valid;
assign pop     = (count != '0) && (credits != '0);
assign pending = {1'b0, count} + {{mmu_pkg::QCNT_BITS{1'b0}}, i_xlate.valid};
assign o_space = pending < {1'b0, mmu_pkg::QUEUE_FULL};

assign o_req = '{valid: pop, paddr: paddr_mem[rd_ptr], opc: opc_mem[rd_ptr]};

// ----------------------------------------
// FIFO
// ----------------------------------------
always_ff @(posedge clk) begin
    if (push) begin
        paddr_mem[wr_ptr] <= i_xlate.paddr;
        opc_mem[wr_ptr]   <= i_xlate.opc;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push)
            wr_ptr <= wr_ptr + 1'b1;            // Wraps at the power-of-two depth
        if (pop)
            rd_ptr <= rd_ptr + 1'b1;
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // Push and pop cancel out
        endcase
    end
end

// ----------------------------------------
// Credit counter
// ----------------------------------------
always_ff @(posedge clk) begin
    if (reset)
        credits <= mmu_pkg::CREDIT_MAX;         // Full credit after reset
    else begin
        case ({pop, i_credit_ret})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
        endcase
    end
end

// Space check at the top keeps a full FIFO from receiving a push
a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> (count < mmu_pkg::QUEUE_FULL))
    else $error("push into a full request queue");

// Arbiter must not return more than it received
a_credit_max: assert property (@(posedge clk) disable iff (reset)
    credits <= mmu_pkg::BUS_CREDITS)
    else $error("credit count above maximum");

endmodule

// ==== design/mmu_pkg.sv ====
/*
 * Sizes, command kinds and bus types shared by the MMU units
 * Map and status memories are fixed at 1024 pages of 1024 words
 * A map entry is 20 bits and its upper ten bits name the physical page
 */
package mmu_pkg;

// ----------------------------------------
// Sizes
// ----------------------------------------
localparam int PAGE_BITS       = 10;                        // Page index width
localparam int PAGES           = 1 << PAGE_BITS;            // Map entries
localparam int OFFSET_BITS     = 10;                        // In-page word offset
localparam int ADDR_BITS       = PAGE_BITS + OFFSET_BITS;   // Virtual and physical
localparam int BESM6_PAGE_BITS = 5;                         // Virtual page in BESM-6 mode
localparam int BUS_CREDITS     = 4;                         // Arbiter credits after reset
localparam int QUEUE_DEPTH     = 4;                         // Request FIFO entries

localparam int QPTR_BITS   = $clog2(QUEUE_DEPTH);           // FIFO pointer
localparam int QCNT_BITS   = $clog2(QUEUE_DEPTH + 1);       // FIFO fill level
localparam int CREDIT_BITS = $clog2(BUS_CREDITS + 1);       // Credit counter

localparam logic [QCNT_BITS-1:0]   QUEUE_FULL = QCNT_BITS'(QUEUE_DEPTH);
localparam logic [CREDIT_BITS-1:0] CREDIT_MAX = CREDIT_BITS'(BUS_CREDITS);

// ----------------------------------------
// Opcodes and command kinds
// ----------------------------------------
typedef logic [3:0] arb_opc_t;                  // Arbiter opcode

localparam arb_opc_t ARB_CCWR  = 4'd2;          // Instruction cache write
localparam arb_opc_t ARB_DCWR  = 4'd4;          // Operand cache write
localparam arb_opc_t ARB_DWR   = 4'd10;         // Result write
localparam arb_opc_t ARB_RDMWR = 4'd11;         // Read-modify-write
localparam arb_opc_t ARB_BTRWR = 4'd12;         // Block transfer write

typedef enum logic [2:0] {
    CMD_NOP       = 3'd0,
    CMD_MAP_WR    = 3'd1,   // Write one map entry
    CMD_STAT_WR   = 3'd2,   // Write used and dirty bits
    CMD_REPRIO_WR = 3'd3,   // Write one reprioritize bit
    CMD_FILL      = 3'd4,   // Set reprioritize bits up to the last page
    CMD_READ      = 3'd5,   // Read entry and status of a page
    CMD_XLATE     = 3'd6    // Translate and queue a bus request
} cmd_kind_t;

// ----------------------------------------
// Structs
// ----------------------------------------
typedef struct packed {
    logic                 valid;
    cmd_kind_t            kind;
    logic [ADDR_BITS-1:0] vaddr;    // Page index sits in the upper bits
    logic [ADDR_BITS-1:0] data;     // Entry, or reprio/used/dirty in bits 0..2
    arb_opc_t             opc;
} mmu_cmd_t;

typedef struct packed {
    logic besm6;                    // Five-bit virtual page
    logic no_paging;                // Map bypassed
} mmu_mode_t;

typedef struct packed {
    logic                 valid;
    logic [ADDR_BITS-1:0] paddr;
    logic [PAGE_BITS-1:0] page;     // Physical page for status update
    arb_opc_t             opc;
} xlate_t;

typedef struct packed {
    logic                 valid;
    logic [ADDR_BITS-1:0] entry;
    logic                 used;
    logic                 dirty;
    logic                 reprio;
} rd_resp_t;

typedef struct packed {
    logic                 valid;
    logic [ADDR_BITS-1:0] paddr;
    arb_opc_t             opc;
} bus_req_t;

endpackage

// ==== design/mmu_top.sv ====
`timescale 1ns/1ps

/*
 * Stand-alone memory management unit
 * A command is taken only on a cycle with i_cmd.valid and o_cmd_ready high
 * Ready stays low during a fill and while the request queue is full
 * i_credit_ret must never return more credits than were spent
 */
module mmu_top (
    input  logic                clk,
    input  logic                reset,
    input  mmu_pkg::mmu_cmd_t   i_cmd,          // Command from host
    input  mmu_pkg::mmu_mode_t  i_mode,         // Translation mode
    input  logic                i_credit_ret,   // One credit back from arbiter
    output logic                o_cmd_ready,    // Command can be taken
    output mmu_pkg::rd_resp_t   o_rd,           // Read response
    output mmu_pkg::bus_req_t   o_req,          // Request to arbiter
    output logic                o_fill_busy     // Reprioritize fill running
);

mmu_pkg::mmu_cmd_t              cmd_acc;        // Command qualified by ready
mmu_pkg::xlate_t                xlate;          // Map to status and queue
logic                           queue_space;    // Queue can take one more
logic                           rd_valid;
logic [mmu_pkg::ADDR_BITS-1:0]  rd_entry;
logic                           rd_used;
logic                           rd_dirty;
logic                           rd_reprio;

assign o_cmd_ready = queue_space & ~o_fill_busy;

always_comb begin
    cmd_acc       = i_cmd;
    cmd_acc.valid = i_cmd.valid & o_cmd_ready;  // Only accepted commands go on
end

page_map map_i (
    .clk        (clk),
    .reset      (reset),
    .i_cmd      (cmd_acc),
    .i_mode     (i_mode),
    .o_xlate    (xlate),
    .o_rd_valid (rd_valid),
    .o_rd_entry (rd_entry)
);

page_status status_i (
    .clk         (clk),
    .reset       (reset),
    .i_cmd       (cmd_acc),
    .i_xlate     (xlate),
    .o_used      (rd_used),
    .o_dirty     (rd_dirty),
    .o_reprio    (rd_reprio),
    .o_fill_busy (o_fill_busy)
);

bus_req_queue queue_i (
    .clk          (clk),
    .reset        (reset),
    .i_xlate      (xlate),
    .i_credit_ret (i_credit_ret),
    .o_req        (o_req),
    .o_space      (queue_space)
);

// Entry from the map, status bits aligned from the status unit
assign o_rd = '{valid: rd_valid, entry: rd_entry, used: rd_used,
                dirty: rd_dirty, reprio: rd_reprio};

endmodule

// ==== design/page_map.sv ====
`timescale 1ns/1ps

/*
 * Page map memory and address translation
 * i_cmd must already be qualified by the top-level ready
 * Translation is registered on the accepting edge
 * Read data is valid after the edge that follows acceptance
 */
module page_map (
    input  logic                            clk,
    input  logic                            reset,
    input  mmu_pkg::mmu_cmd_t               i_cmd,      // Accepted command
    input  mmu_pkg::mmu_mode_t              i_mode,     // BESM-6 and no-paging bits
    output mmu_pkg::xlate_t                 o_xlate,    // Registered translation
    output logic                            o_rd_valid, // Read response strobe
    output logic [mmu_pkg::ADDR_BITS-1:0]   o_rd_entry  // Entry read back
);

// ----------------------------------------
// Map memory and command decode
// ----------------------------------------
logic [mmu_pkg::ADDR_BITS-1:0] map_mem [mmu_pkg::PAGES]; // No reset

logic [mmu_pkg::PAGE_BITS-1:0] cmd_page;    // Page index from command
logic [mmu_pkg::PAGE_BITS-1:0] virt_page;   // Page selected by the mode
logic [mmu_pkg::PAGE_BITS-1:0] phys_page;   // Lookup result
logic [mmu_pkg::ADDR_BITS-1:0] map_entry;   // Entry of the virtual page
logic                          map_wr;
logic                          rd_go;
logic                          xlate_go;
logic                          rd_pend;     // Read in first stage
logic [mmu_pkg::PAGE_BITS-1:0] rd_page;     // Page held for the read

assign cmd_page = i_cmd.vaddr[mmu_pkg::ADDR_BITS-1:mmu_pkg::OFFSET_BITS];

assign map_wr   = i_cmd.valid && (i_cmd.kind == mmu_pkg::CMD_MAP_WR);
assign rd_go    = i_cmd.valid && (i_cmd.kind == mmu_pkg::CMD_READ);
assign xlate_go = i_cmd.valid && (i_cmd.kind == mmu_pkg::CMD_XLATE);

// ----------------------------------------
// Translation
// ----------------------------------------
always_comb begin
    virt_page = '0;
    if (i_mode.besm6)                           // Only five page bits, zero-extended
        virt_page[mmu_pkg::BESM6_PAGE_BITS-1:0] =
            i_cmd.vaddr[mmu_pkg::OFFSET_BITS+mmu_pkg::BESM6_PAGE_BITS-1:mmu_pkg::OFFSET_BITS];
    else
        virt_page = cmd_page;                   // Full ten-bit page
end

assign map_entry = map_mem[virt_page];
assign phys_page = i_mode.no_paging
                 ? virt_page                    // Map bypassed
                 : map_entry[mmu_pkg::ADDR_BITS-1:mmu_pkg::ADDR_BITS-mmu_pkg::PAGE_BITS];

always_ff @(posedge clk) begin
    if (reset)
        o_xlate.valid <= 1'b0;
    else
        o_xlate.valid <= xlate_go;
    o_xlate.paddr <= {phys_page, i_cmd.vaddr[mmu_pkg::OFFSET_BITS-1:0]};
    o_xlate.page  <= phys_page;                 // Status bits follow the physical page
    o_xlate.opc   <= i_cmd.opc;
end

// ----------------------------------------
// Map write and two-stage read
// ----------------------------------------
always_ff @(posedge clk) begin
    if (map_wr)
        map_mem[cmd_page] <= i_cmd.data;        // Visible from the accepting edge
end

always_ff @(posedge clk) begin
    if (reset) begin
        rd_pend    <= 1'b0;
        o_rd_valid <= 1'b0;
    end else begin
        rd_pend    <= rd_go;
        o_rd_valid <= rd_pend;                  // One-cycle response
    end
end

always_ff @(posedge clk) begin
    if (rd_go)
        rd_page <= cmd_page;
    o_rd_entry <= map_mem[rd_page];             // Same edge as status read
end

endmodule

// ==== design/page_status.sv ====
`timescale 1ns/1ps

/*
 * Used, dirty and reprioritize bits per physical page
 * Translations update status one edge after they leave the map
 * A fill sets one reprioritize bit per cycle through page 1023
 * Commands are not accepted while the fill runs
 */
module page_status (
    input  logic                clk,
    input  logic                reset,
    input  mmu_pkg::mmu_cmd_t   i_cmd,          // Accepted command
    input  mmu_pkg::xlate_t     i_xlate,        // Translation from the map
    output logic                o_used,         // Read response bits
    output logic                o_dirty,
    output logic                o_reprio,
    output logic                o_fill_busy     // Fill sequence running
);

// ----------------------------------------
// Status arrays and decode
// ----------------------------------------
logic [mmu_pkg::PAGES-1:0]      used_bits;      // Page referenced
logic [mmu_pkg::PAGES-1:0]      dirty_bits;     // Page modified
logic [mmu_pkg::PAGES-1:0]      reprio_bits;    // Reprioritize request

logic [mmu_pkg::PAGE_BITS-1:0]  cmd_page;
logic [mmu_pkg::PAGE_BITS-1:0]  fill_cnt;       // Next page to fill
logic [mmu_pkg::PAGE_BITS-1:0]  rd_page;        // Page held for the read
logic                           stat_wr;
logic                           reprio_wr;
logic                           fill_go;
logic                           rd_go;
logic                           wr_opc;         // Opcode modifies memory

assign cmd_page = i_cmd.vaddr[mmu_pkg::ADDR_BITS-1:mmu_pkg::OFFSET_BITS];

assign stat_wr   = i_cmd.valid && (i_cmd.kind == mmu_pkg::CMD_STAT_WR);
assign reprio_wr = i_cmd.valid && (i_cmd.kind == mmu_pkg::CMD_REPRIO_WR);
assign fill_go   = i_cmd.valid && (i_cmd.kind == mmu_pkg::CMD_FILL);
assign rd_go     = i_cmd.valid && (i_cmd.kind == mmu_pkg::CMD_READ);

always_comb begin
    case (i_xlate.opc)
        mmu_pkg::ARB_CCWR,                      // Instruction cache write
        mmu_pkg::ARB_DCWR,                      // Operand cache write
        mmu_pkg::ARB_DWR,                       // Result write
        mmu_pkg::ARB_RDMWR,                     // Read-modify-write
        mmu_pkg::ARB_BTRWR: wr_opc = 1'b1;      // Block transfer write
        default:            wr_opc = 1'b0;
    endcase
end

// ----------------------------------------
// Used and dirty bits
// ----------------------------------------
always_ff @(posedge clk) begin
    if (i_xlate.valid) begin
        used_bits[i_xlate.page] <= 1'b1;
        if (wr_opc)
            dirty_bits[i_xlate.page] <= 1'b1;
    end
    if (stat_wr) begin                          // Later command wins over the update
        used_bits[cmd_page]  <= i_cmd.data[1];
        dirty_bits[cmd_page] <= i_cmd.data[2];
    end
end

// ----------------------------------------
// Reprioritize bits and fill sequencer
// ----------------------------------------
always_ff @(posedge clk) begin
    if (reset) begin
        o_fill_busy <= 1'b0;
        fill_cnt    <= '0;
    end else if (o_fill_busy) begin
        fill_cnt <= fill_cnt + 1'b1;
        if (&fill_cnt)                          // Last page written this edge
            o_fill_busy <= 1'b0;
    end else if (fill_go) begin
        o_fill_busy <= 1'b1;
        fill_cnt    <= cmd_page;                // Start page from the command
    end
end

always_ff @(posedge clk) begin
    if (o_fill_busy)
        reprio_bits[fill_cnt] <= 1'b1;
    else if (reprio_wr)
        reprio_bits[cmd_page] <= i_cmd.data[0];
end

// ----------------------------------------
// Read path, aligned with the map read
// ----------------------------------------
always_ff @(posedge clk) begin
    if (rd_go)
        rd_page <= cmd_page;
    o_used   <= used_bits[rd_page];             // Sees an update from the edge before
    o_dirty  <= dirty_bits[rd_page];
    o_reprio <= reprio_bits[rd_page];
end

// Ready gating at the top keeps fills from overlapping
a_fill_overlap: assert property (@(posedge clk) disable iff (reset)
    fill_go |-> !o_fill_busy)
    else $error("fill started while a fill is busy");

endmodule

// ==== flist.f ====
design/mmu_pkg.sv
design/page_map.sv
design/page_status.sv
design/bus_req_queue.sv
design/mmu_top.sv
sim/tb_clock.sv
sim/tb_mmu.sv

// ==== sim/mmu_stim.txt ====
# kind vaddr data opc mode hold exp_a exp_b, all hex; kind 1 map 2 stat 3 reprio 4 fill 5 read 6 xlate
# mode bit1 besm6 bit0 no_paging; exp_a paddr, entry or fill cycles; exp_b dirty used reprio
1 01400 48CAB 0 0 0 00000 0
1 01800 BC001 0 0 0 00000 0
1 B1400 02812 0 0 0 00000 0
1 48C00 00777 0 0 0 00000 0
1 BC000 11111 0 0 0 00000 0
1 02800 0ABCD 0 0 0 00000 0
2 48C00 00000 0 0 0 00000 0
2 BC000 00000 0 0 0 00000 0
2 02800 00000 0 0 0 00000 0
3 48C00 00000 0 0 0 00000 0
3 BC000 00000 0 0 0 00000 0
3 02800 00001 0 0 0 00000 0
5 48C00 00000 0 0 0 00777 0
6 01405 00000 1 0 0 48C05 0
5 48C00 00000 0 0 0 00777 2
6 01BFF 00000 A 0 0 BC3FF 0
5 BC000 00000 0 0 0 11111 6
6 B1677 00000 3 0 0 02A77 0
5 02800 00000 0 0 0 0ABCD 3
6 B1677 00000 C 2 0 48E77 0
5 48C00 00000 0 0 0 00777 6
6 3FC12 00000 4 1 0 3FC12 0
2 BC000 00002 0 0 0 00000 0
5 BC000 00000 0 0 0 11111 2
6 01800 00000 D 0 0 BC000 0
5 BC000 00000 0 0 0 11111 2
6 01800 00000 B 0 0 BC000 0
5 BC000 00000 0 0 0 11111 6
6 B1401 00000 2 0 0 02801 0
5 02800 00000 0 0 0 0ABCD 7
1 F9C00 3E7AA 0 0 0 00000 0
1 FA000 3E855 0 0 0 00000 0
1 FFC00 FFC01 0 0 0 00000 0
2 F9C00 00000 0 0 0 00000 0
2 FA000 00006 0 0 0 00000 0
2 FFC00 00002 0 0 0 00000 0
3 F9C00 00000 0 0 0 00000 0
3 FA000 00000 0 0 0 00000 0
3 FFC00 00000 0 0 0 00000 0
4 FA000 00000 0 0 0 00018 0
5 F9C00 00000 0 0 0 3E7AA 0
5 FA000 00000 0 0 0 3E855 7
5 FFC00 00000 0 0 0 FFC01 3
6 01410 00000 1 0 28 48C10 0
6 01420 00000 2 0 0 48C20 0
6 01430 00000 3 0 0 48C30 0
6 01440 00000 B 0 0 48C40 0
6 01450 00000 5 0 0 48C50 0
6 01460 00000 6 0 0 48C60 0
6 01470 00000 7 0 0 48C70 0
6 01480 00000 8 0 0 48C80 0
6 01490 00000 9 0 0 48C90 0
6 3FC01 00000 0 1 0 3FC01 0

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

/*
 * Free-running 10 ns clock for the MMU testbench
 * Reset is high for the first four rising edges and drops 1 ns after the fourth
 */
module tb_clock (
    output logic clk,
    output logic reset
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                  // 10 ns period
end

initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);              // Four cycles in reset
    #1 reset = 1'b0;                        // Released just after the edge
end

endmodule

// ==== sim/tb_mmu.sv ====
`timescale 1ns/1ps

/*
 * Testbench for mmu_top, stimulus and expected values from sim/mmu_stim.txt
 * Run from the project root so that the stim path resolves
 * Commands go in 1 ns after the rising edge and are held until o_cmd_ready
 * The arbiter model returns each credit after a random delay of 1 to 6 cycles
 */
module tb_mmu;

typedef struct packed {
    logic [2:0]  kind;
    logic [19:0] vaddr;
    logic [19:0] data;
    logic [3:0]  opc;
    logic [1:0]  mode;          // besm6, no_paging
    logic [7:0]  hold;          // Cycles to withhold credits
    logic [19:0] exp_a;         // Address, entry or fill length
    logic [2:0]  exp_b;         // Dirty, used, reprio
} stim_t;

logic               clk;
logic               reset;
mmu_pkg::mmu_cmd_t  i_cmd;
mmu_pkg::mmu_mode_t i_mode;
logic               i_credit_ret;
logic               o_cmd_ready;
mmu_pkg::rd_resp_t  o_rd;
mmu_pkg::bus_req_t  o_req;
logic               o_fill_busy;

stim_t              stim_q[$];
mmu_pkg::bus_req_t  exp_reqs[$];            // Requests in acceptance order
mmu_pkg::rd_resp_t  exp_rds[$];
int                 due_q[$];               // Cycle at which each credit goes back
int                 delay_q[$];             // Credit return delays, drawn up front
int                 cycle_count  = 0;
int                 cycle_limit  = 0;
int                 hold_until   = 0;       // Credits withheld before this cycle
int                 reqs_seen    = 0;
int                 credits_back = 0;
int                 value_errs   = 0;
int                 other_errs   = 0;
logic               credit_due;
logic               hold_used    = 1'b0;
logic               stall_seen   = 1'b0;    // Ready fell under back-pressure

tb_clock clock_i (
    .clk   (clk),
    .reset (reset)
);

mmu_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .i_cmd        (i_cmd),
    .i_mode       (i_mode),
    .i_credit_ret (i_credit_ret),
    .o_cmd_ready  (o_cmd_ready),
    .o_rd         (o_rd),
    .o_req        (o_req),
    .o_fill_busy  (o_fill_busy)
);

// ----------------------------------------
// Error reporting
// ----------------------------------------
task automatic note_mismatch(input string sig, input logic [31:0] got, input logic [31:0] want);
    $display("ERR %0t %s got %0h expected %0h", $time, sig, got, want);
    value_errs = value_errs + 1;
endtask

task automatic note_failure(input string what);
    $display("FAIL %0t %s", $time, what);
    other_errs = other_errs + 1;
endtask

// ----------------------------------------
// Stim file
// ----------------------------------------
task automatic load_stim;
    int    fd;
    int    n;
    int    k, va, d, o, m, h, ea, eb;
    string line;
    stim_t s;
    fd = $fopen("sim/mmu_stim.txt", "r");
    if (fd == 0) begin
        note_failure("cannot open sim/mmu_stim.txt");
    end else begin
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin     // Skip blanks and comments
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", k, va, d, o, m, h, ea, eb);
                if (n == 8) begin
                    s = '{kind: k[2:0], vaddr: va[19:0], data: d[19:0], opc: o[3:0],
                          mode: m[1:0], hold: h[7:0], exp_a: ea[19:0], exp_b: eb[2:0]};
                    stim_q.push_back(s);
                end else begin
                    note_failure("malformed line in the stim file");
                end
            end
        end
        $fclose(fd);
    end
    if (stim_q.size() == 0)
        note_failure("stim file holds no commands");
endtask

// ----------------------------------------
// Command driver, called 1 ns after an edge
// ----------------------------------------
task automatic apply_line(input stim_t s);
    int                busy_cycles;
    mmu_pkg::bus_req_t req_want;
    mmu_pkg::rd_resp_t rd_want;
    busy_cycles = 0;
    if (s.hold != 0) begin
        hold_until = cycle_count + int'(s.hold);    // Arbiter sits on its credits
        hold_used  = 1'b1;
    end
    i_mode = mmu_pkg::mmu_mode_t'(s.mode);
    i_cmd  = '{valid: 1'b1, kind: mmu_pkg::cmd_kind_t'(s.kind), vaddr: s.vaddr,
               data: s.data, opc: s.opc};
    @(negedge clk);
    while (!o_cmd_ready)
        @(negedge clk);                             // Taken at the coming edge
    if (s.kind == 3'd6) begin                       // Translate
        req_want = '{valid: 1'b1, paddr: s.exp_a, opc: s.opc};
        exp_reqs.push_back(req_want);
    end
    if (s.kind == 3'd5) begin                       // Read
        rd_want = '{valid: 1'b1, entry: s.exp_a, used: s.exp_b[1],
                    dirty: s.exp_b[2], reprio: s.exp_b[0]};
        exp_rds.push_back(rd_want);
    end
    @(posedge clk);
    #1;
    i_cmd.valid = 1'b0;
    if (s.kind == 3'd4) begin                       // Fill, one page per cycle
        while (o_fill_busy) begin
            busy_cycles = busy_cycles + 1;
            @(posedge clk);
            #1;
        end
        assert (busy_cycles == int'(s.exp_a))
            else note_mismatch("o_fill_busy cycles", busy_cycles, s.exp_a);
    end
endtask

// ----------------------------------------
// Response checks
// ----------------------------------------
task automatic check_request;
    mmu_pkg::bus_req_t want;
    int                delay;
    reqs_seen = reqs_seen + 1;
    assert (reqs_seen - credits_back <= mmu_pkg::BUS_CREDITS)
        else note_failure("request issued with no credit left at the arbiter");
    delay = 1;
    if (delay_q.size() != 0)
        delay = delay_q.pop_front();
    due_q.push_back(cycle_count + delay);
    assert (exp_reqs.size() != 0) else note_failure("request with no translation pending");
    if (exp_reqs.size() != 0) begin
        want = exp_reqs.pop_front();
        assert (o_req.paddr == want.paddr)
            else note_mismatch("o_req.paddr", o_req.paddr, want.paddr);
        assert (o_req.opc == want.opc)
            else note_mismatch("o_req.opc", o_req.opc, want.opc);
    end
endtask

task automatic check_read;
    mmu_pkg::rd_resp_t want;
    assert (exp_rds.size() != 0) else note_failure("read response with no read pending");
    if (exp_rds.size() != 0) begin
        want = exp_rds.pop_front();
        assert (o_rd.entry == want.entry)
            else note_mismatch("o_rd.entry", o_rd.entry, want.entry);
        assert (o_rd.used == want.used)
            else note_mismatch("o_rd.used", o_rd.used, want.used);
        assert (o_rd.dirty == want.dirty)
            else note_mismatch("o_rd.dirty", o_rd.dirty, want.dirty);
        assert (o_rd.reprio == want.reprio)
            else note_mismatch("o_rd.reprio", o_rd.reprio, want.reprio);
    end
endtask

// Outputs are settled mid-cycle
always @(negedge clk) begin
    if (!reset) begin
        if (o_req.valid)
            check_request();
        if (o_rd.valid)
            check_read();
        if (o_fill_busy)
            assert (!o_cmd_ready) else note_failure("o_cmd_ready high during a fill");
        if (!o_cmd_ready && !o_fill_busy && cycle_count < hold_until)
            stall_seen = 1'b1;
    end
end

// Arbiter credit return, decided at the edge and driven 1 ns later
always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    credit_due  = (due_q.size() != 0) && (due_q[0] <= cycle_count)
               && (cycle_count >= hold_until);
    #1;
    i_credit_ret = credit_due;
    if (credit_due) begin
        void'(due_q.pop_front());
        credits_back = credits_back + 1;
    end
end

// ----------------------------------------
// Main sequence and watchdog
// ----------------------------------------
initial begin
    i_cmd        = '0;
    i_mode       = '0;
    i_credit_ret = 1'b0;
    void'($urandom(80561));
    load_stim();
    foreach (stim_q[i])
        delay_q.push_back(int'($urandom_range(6, 1)));  // At most one request per line
    cycle_limit = 2 * (stim_q.size() + 1100);
    @(negedge reset);
    @(negedge clk);
    assert (o_cmd_ready) else note_mismatch("o_cmd_ready", o_cmd_ready, 1);
    assert (!o_rd.valid) else note_mismatch("o_rd.valid", o_rd.valid, 0);
    assert (!o_req.valid) else note_mismatch("o_req.valid", o_req.valid, 0);
    assert (!o_fill_busy) else note_mismatch("o_fill_busy", o_fill_busy, 0);
    @(posedge clk);
    #1;
    foreach (stim_q[i])
        apply_line(stim_q[i]);
    while (exp_reqs.size() != 0 || exp_rds.size() != 0)
        @(negedge clk);                             // Drain queued requests
    if (hold_used)
        assert (stall_seen)
            else note_failure("o_cmd_ready never fell while credits were held");
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

initial begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit)
        @(negedge clk);
    $display("Timeout: run stopped after %0d cycles, %0d requests and %0d reads outstanding",
             cycle_count, exp_reqs.size(), exp_rds.size());
    $display("Done: errors found");
    $finish;
end

endmodule
